// File: include/sys_cfg.svh
// System configuration macros for bus widths, address map and block sizing
`ifndef SYS_CFG_SVH
`define SYS_CFG_SVH

// ----------------------------------------
// Wishbone bus widths
// ----------------------------------------
`define WB_AW 32
`define WB_DW 32
// One select bit per data byte
`define WB_SW 4

// ----------------------------------------
// Address map on bits 31:24
// ----------------------------------------
`define REGION_BOOT  8'h00
`define REGION_TIMER 8'h13
`define REGION_IRQ   8'h14

// Boot RAM depth in 32-bit words (1 KB)
`define BOOT_WORDS 256

// System reset hold time in board clocks after release
`define RST_STRETCH 16

// ----------------------------------------
// Register byte offsets on bits 3:0
// ----------------------------------------
// Timer
`define TMR_LOAD   4'h0
`define TMR_VALUE  4'h4
`define TMR_CTRL   4'h8
`define TMR_CLEAR  4'hC
// Interrupt controller
`define IC_RAW     4'h0
`define IC_IRQ_EN  4'h4
`define IC_FIRQ_EN 4'h8
`define IC_STATUS  4'hC

`endif

// File: hw/sys_pkg.sv
// Shared bus structs and region encoding for the system fabric
`include "sys_cfg.svh"

package sys_pkg;

    // ----------------------------------------
    // Wishbone request, master to slave
    // ----------------------------------------
    // Total 71 bits
    typedef struct packed {
        // Byte address
        logic [`WB_AW-1:0] adr;
        // Byte lane selects
        logic [`WB_SW-1:0] sel;
        // Write enable
        logic              we;
        // Write data
        logic [`WB_DW-1:0] dat;
        // Cycle and strobe
        logic              cyc;
        logic              stb;
    } wb_req_t;

    // ----------------------------------------
    // Wishbone response, slave to master
    // ----------------------------------------
    // Total 34 bits
    typedef struct packed {
        // Read data
        logic [`WB_DW-1:0] dat;
        // Single-cycle terminations
        logic              ack;
        logic              err;
    } wb_rsp_t;

    // Decoded target of the current access
    typedef enum logic [1:0] {
        region_boot,
        region_timer,
        region_irq,
        region_none
    } region_e;

endpackage

// File: hw/rst_stretch.sv
// Reset stretcher holding system reset for a fixed count after board reset release
`timescale 1ns/10ps
`include "sys_cfg.svh"

module rst_stretch (
    input  logic i_brd_clk,
    input  logic i_brd_rst,
    output logic o_sys_rst,
    output logic o_sys_rdy
);

    // Wide enough for the full stretch count
    localparam int CNT_W = $clog2(`RST_STRETCH + 1);

    logic [CNT_W-1:0] cnt_q;
    logic             rst_q;

    // Board reset restarts the count
    // Release after RST_STRETCH clocks of board reset high
    always_ff @(posedge i_brd_clk) begin
        if (!i_brd_rst) begin
            cnt_q <= '0;
            rst_q <= 1'b1;
        end else if (rst_q) begin
            if (cnt_q == CNT_W'(`RST_STRETCH - 1)) begin
                rst_q <= 1'b0;
            end else begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

    // Active high system reset
    assign o_sys_rst = rst_q;
    // Ready level for the core
    assign o_sys_rdy = ~rst_q;

endmodule

// File: hw/wb_decoder.sv
// Wishbone address decoder routing one master to the boot RAM, timer and interrupt controller
`timescale 1ns/10ps
`include "sys_cfg.svh"

module wb_decoder (
    input  logic             i_clk,
    input  logic             i_rst,
    input  sys_pkg::wb_req_t i_wb,
    output sys_pkg::wb_rsp_t o_wb,
    output sys_pkg::wb_req_t o_boot_req,
    output sys_pkg::wb_req_t o_tmr_req,
    output sys_pkg::wb_req_t o_ic_req,
    input  sys_pkg::wb_rsp_t i_boot_rsp,
    input  sys_pkg::wb_rsp_t i_tmr_rsp,
    input  sys_pkg::wb_rsp_t i_ic_rsp
);

    sys_pkg::region_e region;
    logic             err_q;

    // ----------------------------------------
    // Region decode on the top address byte
    // ----------------------------------------
    always_comb begin
        case (i_wb.adr[31:24])
            `REGION_BOOT:  region = sys_pkg::region_boot;
            `REGION_TIMER: region = sys_pkg::region_timer;
            `REGION_IRQ:   region = sys_pkg::region_irq;
            default:       region = sys_pkg::region_none;
        endcase
    end

    // Request fan-out
    // Only the selected block sees cyc and stb
    always_comb begin
        o_boot_req     = i_wb;
        o_tmr_req      = i_wb;
        o_ic_req       = i_wb;
        o_boot_req.cyc = i_wb.cyc & (region == sys_pkg::region_boot);
        o_boot_req.stb = i_wb.stb & (region == sys_pkg::region_boot);
        o_tmr_req.cyc  = i_wb.cyc & (region == sys_pkg::region_timer);
        o_tmr_req.stb  = i_wb.stb & (region == sys_pkg::region_timer);
        o_ic_req.cyc   = i_wb.cyc & (region == sys_pkg::region_irq);
        o_ic_req.stb   = i_wb.stb & (region == sys_pkg::region_irq);
    end

    // Unmapped access error
    // One-cycle pulse, a held strobe repeats it every other cycle
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            err_q <= 1'b0;
        end else begin
            err_q <= i_wb.cyc & i_wb.stb & (region == sys_pkg::region_none) & ~err_q;
        end
    end

    // ----------------------------------------
    // Response return mux
    // ----------------------------------------
    // Address is held by the master through ack
    always_comb begin
        case (region)
            sys_pkg::region_boot:  o_wb = i_boot_rsp;
            sys_pkg::region_timer: o_wb = i_tmr_rsp;
            sys_pkg::region_irq:   o_wb = i_ic_rsp;
            default: begin
                o_wb.dat = '0;
                o_wb.ack = 1'b0;
                o_wb.err = 1'b0;
            end
        endcase
        // Decoder error merged on top
        o_wb.err = o_wb.err | err_q;
    end

endmodule

// File: hw/boot_ram.sv
// Word-addressed on-chip boot RAM with byte-lane writes on the Wishbone bus
`timescale 1ns/10ps
`include "sys_cfg.svh"

module boot_ram (
    input  logic             i_clk,
    input  logic             i_rst,
    input  sys_pkg::wb_req_t i_req,
    output sys_pkg::wb_rsp_t o_rsp
);

    // Word index width, 8 bits for 256 words
    localparam int IDX_W = $clog2(`BOOT_WORDS);

    logic [`WB_DW-1:0] mem [`BOOT_WORDS];
    logic [`WB_DW-1:0] rd_q;
    logic [IDX_W-1:0]  idx;
    logic              access;
    logic              ack_q;

    // Word address from byte address
    assign idx    = i_req.adr[IDX_W+1:2];
    // First cycle of a strobe only
    assign access = i_req.cyc & i_req.stb & ~ack_q;

    // Array write and registered read
    always_ff @(posedge i_clk) begin
        if (access) begin
            if (i_req.we) begin
                for (int b = 0; b < `WB_SW; b++) begin
                    if (i_req.sel[b]) begin
                        mem[idx][b*8 +: 8] <= i_req.dat[b*8 +: 8];
                    end
                end
            end
            // Old contents on a write cycle
            rd_q <= mem[idx];
        end
    end

    // Ack one cycle after strobe
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    assign o_rsp.dat = rd_q;
    assign o_rsp.ack = ack_q;
    // Every word is mapped
    assign o_rsp.err = 1'b0;

endmodule

// File: hw/timer_block.sv
// Down-counting timer with reload, one-shot or periodic mode and a level interrupt
`timescale 1ns/10ps
`include "sys_cfg.svh"

module timer_block (
    input  logic             i_clk,
    input  logic             i_rst,
    input  sys_pkg::wb_req_t i_req,
    output sys_pkg::wb_rsp_t o_rsp,
    output logic             o_tmr_int
);

    localparam int DW = `WB_DW;

    logic [DW-1:0] load_q;
    logic [DW-1:0] value_q;
    logic [1:0]    ctrl_q;
    logic          int_q;
    logic          ack_q;
    logic [DW-1:0] rd_q;
    logic [3:0]    offset;
    logic          access;
    logic          wr;

    // Byte-lane merge of a bus write into a register
    function automatic logic [DW-1:0] merge_bytes(input logic [DW-1:0] old_val,
                                                  input logic [DW-1:0] new_val,
                                                  input logic [`WB_SW-1:0] sel);
        logic [DW-1:0] res;
        res = old_val;
        for (int b = 0; b < `WB_SW; b++) begin
            if (sel[b]) begin
                res[b*8 +: 8] = new_val[b*8 +: 8];
            end
        end
        return res;
    endfunction

    assign offset = i_req.adr[3:0];
    assign access = i_req.cyc & i_req.stb & ~ack_q;
    assign wr     = access & i_req.we;

    // ----------------------------------------
    // Counter and register writes
    // ----------------------------------------
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            load_q  <= '0;
            value_q <= '0;
            ctrl_q  <= '0;
            int_q   <= 1'b0;
            ack_q   <= 1'b0;
        end else begin
            ack_q <= access;
            // Count down while enabled
            if (ctrl_q[0]) begin
                if (value_q == '0) begin
                    int_q <= 1'b1;
                    // Periodic reload, else one-shot stop
                    if (ctrl_q[1]) begin
                        value_q <= load_q;
                    end else begin
                        ctrl_q[0] <= 1'b0;
                    end
                end else begin
                    value_q <= value_q - 1'b1;
                end
            end
            // Bus writes override the counter
            if (wr) begin
                case (offset)
                    `TMR_LOAD: begin
                        load_q  <= merge_bytes(load_q, i_req.dat, i_req.sel);
                        value_q <= merge_bytes(load_q, i_req.dat, i_req.sel);
                    end
                    `TMR_CTRL: if (i_req.sel[0]) ctrl_q <= i_req.dat[1:0];
                    `TMR_CLEAR: int_q <= 1'b0;
                    default: ;
                endcase
            end
        end
    end

    // Read data registered with ack
    always_ff @(posedge i_clk) begin
        if (access) begin
            case (offset)
                `TMR_LOAD:  rd_q <= load_q;
                `TMR_VALUE: rd_q <= value_q;
                `TMR_CTRL:  rd_q <= DW'(ctrl_q);
                default:    rd_q <= '0;
            endcase
        end
    end

    assign o_rsp.dat = rd_q;
    assign o_rsp.ack = ack_q;
    assign o_rsp.err = 1'b0;
    assign o_tmr_int = int_q;

endmodule

// File: hw/irq_ctrl.sv
// Interrupt controller with separate IRQ and FIRQ enable masks over timer and external sources
`timescale 1ns/10ps
`include "sys_cfg.svh"

module irq_ctrl (
    input  logic             i_clk,
    input  logic             i_rst,
    input  sys_pkg::wb_req_t i_req,
    output sys_pkg::wb_rsp_t o_rsp,
    input  logic             i_tmr_int,
    input  logic             i_ext_irq,
    output logic             o_irq,
    output logic             o_firq
);

    localparam int DW = `WB_DW;

    logic [1:0]    raw;
    logic [1:0]    irq_en_q;
    logic [1:0]    firq_en_q;
    logic          ack_q;
    logic [DW-1:0] rd_q;
    logic [3:0]    offset;
    logic          access;

    // Bit 0 timer, bit 1 external line
    assign raw    = {i_ext_irq, i_tmr_int};
    assign offset = i_req.adr[3:0];
    assign access = i_req.cyc & i_req.stb & ~ack_q;

    // ----------------------------------------
    // Enable masks and ack
    // ----------------------------------------
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            irq_en_q  <= '0;
            firq_en_q <= '0;
            ack_q     <= 1'b0;
        end else begin
            ack_q <= access;
            // Masks live in byte lane 0
            if (access && i_req.we && i_req.sel[0]) begin
                case (offset)
                    `IC_IRQ_EN:  irq_en_q  <= i_req.dat[1:0];
                    `IC_FIRQ_EN: firq_en_q <= i_req.dat[1:0];
                    default: ;
                endcase
            end
        end
    end

    // Read data registered with ack
    always_ff @(posedge i_clk) begin
        if (access) begin
            case (offset)
                `IC_RAW:     rd_q <= DW'(raw);
                `IC_IRQ_EN:  rd_q <= DW'(irq_en_q);
                `IC_FIRQ_EN: rd_q <= DW'(firq_en_q);
                `IC_STATUS:  rd_q <= DW'(raw & irq_en_q);
                default:     rd_q <= '0;
            endcase
        end
    end

    assign o_rsp.dat = rd_q;
    assign o_rsp.ack = ack_q;
    assign o_rsp.err = 1'b0;

    // Combinational request lines to the core
    assign o_irq  = |(raw & irq_en_q);
    assign o_firq = |(raw & firq_en_q);

endmodule

// File: hw/soc_top.sv
// System top level with reset stretcher, Wishbone decoder, boot RAM, timer, interrupts and LEDs
`timescale 1ns/10ps

module soc_top (
    input  logic             brd_clk,
    input  logic             brd_rst,
    input  sys_pkg::wb_req_t i_wb,
    output sys_pkg::wb_rsp_t o_wb,
    input  logic             i_ext_irq,
    output logic             o_irq,
    output logic             o_firq,
    output logic             o_sys_rdy,
    output logic [7:0]       o_led_bar
);

    // Active high, synchronous to brd_clk
    logic             sys_rst;
    logic             tmr_int;
    sys_pkg::wb_req_t boot_req;
    sys_pkg::wb_req_t tmr_req;
    sys_pkg::wb_req_t ic_req;
    sys_pkg::wb_rsp_t boot_rsp;
    sys_pkg::wb_rsp_t tmr_rsp;
    sys_pkg::wb_rsp_t ic_rsp;

    // ----------------------------------------
    // Reset and bus fabric
    // ----------------------------------------
    rst_stretch u_rst_stretch (
        .i_brd_clk (brd_clk),
        .i_brd_rst (brd_rst),
        .o_sys_rst (sys_rst),
        .o_sys_rdy (o_sys_rdy)
    );

    wb_decoder u_decoder (
        .i_clk      (brd_clk),
        .i_rst      (sys_rst),
        .i_wb       (i_wb),
        .o_wb       (o_wb),
        .o_boot_req (boot_req),
        .o_tmr_req  (tmr_req),
        .o_ic_req   (ic_req),
        .i_boot_rsp (boot_rsp),
        .i_tmr_rsp  (tmr_rsp),
        .i_ic_rsp   (ic_rsp)
    );

    // Slaves
    boot_ram u_boot_ram (
        .i_clk (brd_clk),
        .i_rst (sys_rst),
        .i_req (boot_req),
        .o_rsp (boot_rsp)
    );

    timer_block u_timer (
        .i_clk     (brd_clk),
        .i_rst     (sys_rst),
        .i_req     (tmr_req),
        .o_rsp     (tmr_rsp),
        .o_tmr_int (tmr_int)
    );

    irq_ctrl u_irq_ctrl (
        .i_clk     (brd_clk),
        .i_rst     (sys_rst),
        .i_req     (ic_req),
        .o_rsp     (ic_rsp),
        .i_tmr_int (tmr_int),
        .i_ext_irq (i_ext_irq),
        .o_irq     (o_irq),
        .o_firq    (o_firq)
    );

    // LED bar follows the low address byte
    assign o_led_bar = i_wb.adr[7:0];

endmodule

// File: testbench/soc_checker.sv
// Bound assertion checker for the system top level with a shadow of boot RAM writes
`timescale 1ns/10ps
`include "sys_cfg.svh"

module soc_checker (
    input logic             i_brd_clk,
    input logic             i_brd_rst,
    input sys_pkg::wb_req_t i_wb,
    input sys_pkg::wb_rsp_t i_rsp,
    input logic             i_ext_irq,
    input logic             i_tmr_int,
    input logic             i_irq,
    input logic             i_firq,
    input logic             i_sys_rdy,
    input logic [7:0]       i_led_bar
);

    // Failures so far, watched from the testbench
    int fail_cnt = 0;

    logic [`WB_DW-1:0]      shadow [`BOOT_WORDS];
    logic [`BOOT_WORDS-1:0] valid;
    logic [`WB_DW-1:0]      load_sh;
    logic [`WB_DW-1:0]      tmr_wait;
    logic [`WB_DW-1:0]      exp_q;
    logic [1:0]             irq_en_sh;
    logic [1:0]             firq_en_sh;
    logic [1:0]             raw;
    logic [3:0]             offset;
    logic [7:0]             idx;
    logic                   is_boot;
    logic                   is_tmr;
    logic                   is_ic;
    logic                   stb_q;
    logic                   chk_q;
    logic                   start;
    logic                   clr_start;

    assign is_boot   = i_wb.adr[31:24] == `REGION_BOOT;
    assign is_tmr    = i_wb.adr[31:24] == `REGION_TIMER;
    assign is_ic     = i_wb.adr[31:24] == `REGION_IRQ;
    assign offset    = i_wb.adr[3:0];
    assign idx       = i_wb.adr[9:2];
    // Bit 0 timer, bit 1 external
    assign raw       = {i_ext_irq, i_tmr_int};
    // First sampled cycle of a strobe
    assign start     = i_wb.cyc && i_wb.stb && !stb_q;
    assign clr_start = start && is_tmr && i_wb.we && offset == `TMR_CLEAR;

    // ----------------------------------------
    // Shadow state from bus traffic
    // ----------------------------------------
    always_ff @(posedge i_brd_clk) begin
        if (!i_brd_rst) begin
            valid      <= '0;
            load_sh    <= '0;
            tmr_wait   <= '0;
            irq_en_sh  <= '0;
            firq_en_sh <= '0;
            stb_q      <= 1'b0;
            chk_q      <= 1'b0;
        end else begin
            stb_q <= i_wb.cyc && i_wb.stb;
            chk_q <= 1'b0;
            // Cycles left before the timer may fire
            if (tmr_wait != '0) begin
                tmr_wait <= tmr_wait - 1'b1;
            end
            if (start && i_wb.we) begin
                for (int b = 0; b < `WB_SW; b++) begin
                    if (i_wb.sel[b] && is_boot) begin
                        shadow[idx][b*8 +: 8] <= i_wb.dat[b*8 +: 8];
                    end
                    if (i_wb.sel[b] && is_tmr && offset == `TMR_LOAD) begin
                        load_sh[b*8 +: 8] <= i_wb.dat[b*8 +: 8];
                    end
                end
                // Word known once all four lanes are written
                if (is_boot && i_wb.sel == 4'hf) begin
                    valid[idx] <= 1'b1;
                end
                // LOAD+1 quiet cycles after the ack of an enabling CTRL write
                if (is_tmr && offset == `TMR_CTRL && i_wb.sel[0] && i_wb.dat[0]) begin
                    tmr_wait <= load_sh + 1'b1;
                end
                if (is_ic && i_wb.sel[0] && offset == `IC_IRQ_EN) begin
                    irq_en_sh <= i_wb.dat[1:0];
                end
                if (is_ic && i_wb.sel[0] && offset == `IC_FIRQ_EN) begin
                    firq_en_sh <= i_wb.dat[1:0];
                end
            end else if (start) begin
                // Expected read data, checked with the ack
                chk_q <= 1'b1;
                if (is_boot && valid[idx]) begin
                    exp_q <= shadow[idx];
                end else if (is_tmr && offset == `TMR_LOAD) begin
                    exp_q <= load_sh;
                end else if (is_ic && offset == `IC_STATUS) begin
                    exp_q <= 32'(raw & irq_en_sh);
                end else if (!(is_boot || is_tmr || is_ic)) begin
                    // Unmapped reads return zero data
                    exp_q <= '0;
                end else begin
                    chk_q <= 1'b0;
                end
            end
        end
    end

    // ----------------------------------------
    // Reset
    // ----------------------------------------
    a_rst_len: assert property (@(posedge i_brd_clk)
        $rose(i_brd_rst) |-> (!i_sys_rdy) [*`RST_STRETCH] ##1 i_sys_rdy)
        else begin
            fail_cnt++;
            $error("System ready did not rise %0d cycles after board reset release",
                   `RST_STRETCH);
        end

    // Skips the first cycle, before the stretcher has loaded
    a_rst_quiet: assert property (@(posedge i_brd_clk)
        !i_sys_rdy && !$past(i_sys_rdy) |->
            !i_rsp.ack && !i_rsp.err && !i_irq && !i_firq && !i_tmr_int)
        else begin
            fail_cnt++;
            $error("Ack, err or an interrupt line was active during system reset");
        end

    // ----------------------------------------
    // Bus responses
    // ----------------------------------------
    a_mapped: assert property (@(posedge i_brd_clk)
        start && i_sys_rdy && (is_boot || is_tmr || is_ic) |=> i_rsp.ack && !i_rsp.err)
        else begin
            fail_cnt++;
            $error("Mapped access was not acked without err on the edge after the strobe");
        end

    a_unmapped: assert property (@(posedge i_brd_clk)
        start && i_sys_rdy && !(is_boot || is_tmr || is_ic) |=> i_rsp.err && !i_rsp.ack)
        else begin
            fail_cnt++;
            $error("Unmapped access did not end with err alone on the edge after the strobe");
        end

    a_rdata: assert property (@(posedge i_brd_clk) chk_q |-> i_rsp.dat == exp_q)
        else begin
            fail_cnt++;
            $error("** Error at %0t: o_wb.dat expected %08h got %08h",
                   $time, $sampled(exp_q), $sampled(i_rsp.dat));
        end

    // ----------------------------------------
    // Interrupts
    // ----------------------------------------
    a_irq_mask: assert property (@(posedge i_brd_clk)
        i_sys_rdy |-> {i_firq, i_irq} == {|(raw & firq_en_sh), |(raw & irq_en_sh)})
        else begin
            fail_cnt++;
            $error("** Error at %0t: {o_firq,o_irq} expected %b%b got %b%b", $time,
                   |($sampled(raw) & $sampled(firq_en_sh)),
                   |($sampled(raw) & $sampled(irq_en_sh)),
                   $sampled(i_firq), $sampled(i_irq));
        end

    a_tmr_early: assert property (@(posedge i_brd_clk) tmr_wait != '0 |-> !i_tmr_int)
        else begin
            fail_cnt++;
            $error("Timer interrupt rose before LOAD+1 cycles after the CTRL write ack");
        end

    a_tmr_hold: assert property (@(posedge i_brd_clk)
        i_sys_rdy && i_tmr_int && !clr_start |=> i_tmr_int)
        else begin
            fail_cnt++;
            $error("Timer interrupt dropped without a CLEAR write");
        end

    a_tmr_clear: assert property (@(posedge i_brd_clk) clr_start |=> !i_tmr_int)
        else begin
            fail_cnt++;
            $error("Timer interrupt still set after a CLEAR write");
        end

    // LED bar
    a_led: assert property (@(posedge i_brd_clk) i_led_bar == i_wb.adr[7:0])
        else begin
            fail_cnt++;
            $error("** Error at %0t: o_led_bar expected %02h got %02h",
                   $time, $sampled(i_wb.adr[7:0]), $sampled(i_led_bar));
        end

endmodule

// File: testbench/tb_top.sv
// Testbench for the system top level playing the core on the Wishbone port
`timescale 1ns/10ps
`include "sys_cfg.svh"

module tb_top;

    localparam int N_WORDS = 16;
    // Timer load value
    localparam int TMR_N   = 40;
    // Boot writes, partial writes and reads, then unmapped, timer and interrupt accesses
    localparam int N_ACC   = 3 * N_WORDS + 4 + 6 + 5;
    localparam int WD_CYC  = N_ACC * 4 + `RST_STRETCH + TMR_N + 200;

    logic             brd_clk;
    logic             brd_rst;
    sys_pkg::wb_req_t wb_req;
    sys_pkg::wb_rsp_t wb_rsp;
    logic             ext_irq;
    logic             irq;
    logic             firq;
    logic             sys_rdy;
    logic [7:0]       led_bar;
    logic [31:0]      lfsr;
    logic [7:0]       word_idx [N_WORDS];

    soc_top i_dut (
        .brd_clk   (brd_clk),
        .brd_rst   (brd_rst),
        .i_wb      (wb_req),
        .o_wb      (wb_rsp),
        .i_ext_irq (ext_irq),
        .o_irq     (irq),
        .o_firq    (firq),
        .o_sys_rdy (sys_rdy),
        .o_led_bar (led_bar)
    );

    // Checker sees the top ports and the timer interrupt inside
    bind soc_top soc_checker u_chk (
        .i_brd_clk (brd_clk),
        .i_brd_rst (brd_rst),
        .i_wb      (i_wb),
        .i_rsp     (o_wb),
        .i_ext_irq (i_ext_irq),
        .i_tmr_int (tmr_int),
        .i_irq     (o_irq),
        .i_firq    (o_firq),
        .i_sys_rdy (o_sys_rdy),
        .i_led_bar (o_led_bar)
    );

    // 20 ns clock
    initial begin
        brd_clk = 1'b0;
        forever #10 brd_clk = ~brd_clk;
    end

    // ----------------------------------------
    // Random source
    // ----------------------------------------
    // Galois step, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
        return v;
    endfunction

    function automatic logic [31:0] boot_adr(input logic [7:0] idx);
        return {`REGION_BOOT, 14'h0, idx, 2'b00};
    endfunction

    function automatic logic [31:0] reg_adr(input logic [7:0] region, input logic [3:0] off);
        return {region, 20'h0, off};
    endfunction

    // Single transfer, entered and left on a falling edge
    task automatic bus_access(input logic [31:0] adr, input logic [3:0] sel,
                              input logic we, input logic [31:0] dat);
        wb_req.adr = adr;
        wb_req.sel = sel;
        wb_req.we  = we;
        wb_req.dat = dat;
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        @(negedge brd_clk);
        while (!(wb_rsp.ack || wb_rsp.err)) begin
            @(negedge brd_clk);
        end
        wb_req.cyc = 1'b0;
        wb_req.stb = 1'b0;
        wb_req.we  = 1'b0;
        // Strobe low for one full cycle
        @(negedge brd_clk);
    endtask

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    initial begin
        logic [7:0] top;
        lfsr    = 32'he5ab_18c3;
        brd_rst = 1'b0;
        wb_req  = '0;
        ext_irq = 1'b0;
        repeat (3) @(posedge brd_clk);
        @(negedge brd_clk);
        brd_rst = 1'b1;
        // Boot and unmapped strobes plus the external line while system reset holds
        ext_irq    = 1'b1;
        wb_req.adr = boot_adr(8'h00);
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        repeat (4) @(negedge brd_clk);
        wb_req = '0;
        @(negedge brd_clk);
        wb_req.adr = {8'hff, 24'h00_0000};
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        repeat (4) @(negedge brd_clk);
        wb_req = '0;
        while (sys_rdy !== 1'b1) begin
            @(negedge brd_clk);
        end
        ext_irq = 1'b0;
        // Full words first so every read has a known value
        for (int i = 0; i < N_WORDS; i++) begin
            word_idx[i] = 8'(rand_bits(8));
            bus_access(boot_adr(word_idx[i]), 4'hf, 1'b1, rand_bits(32));
        end
        // Random byte lanes over the same words
        for (int i = 0; i < N_WORDS; i++) begin
            bus_access(boot_adr(word_idx[i]), 4'(rand_bits(4)), 1'b1, rand_bits(32));
        end
        for (int i = 0; i < N_WORDS; i++) begin
            bus_access(boot_adr(word_idx[N_WORDS-1-i]), 4'hf, 1'b0, rand_bits(32));
        end
        // Unmapped, top byte moved off any region
        for (int i = 0; i < 4; i++) begin
            top = 8'(rand_bits(8));
            if (top == `REGION_BOOT || top == `REGION_TIMER || top == `REGION_IRQ) begin
                top = top ^ 8'h80;
            end
            bus_access({top, 24'(rand_bits(24))}, 4'hf, i[0], rand_bits(32));
        end
        // Timer one-shot into IRQ
        bus_access(reg_adr(`REGION_TIMER, `TMR_LOAD), 4'hf, 1'b1, 32'(TMR_N));
        bus_access(reg_adr(`REGION_IRQ, `IC_IRQ_EN), 4'hf, 1'b1, 32'h1);
        bus_access(reg_adr(`REGION_TIMER, `TMR_CTRL), 4'hf, 1'b1, 32'h1);
        while (irq !== 1'b1) begin
            @(negedge brd_clk);
        end
        bus_access(reg_adr(`REGION_TIMER, `TMR_LOAD), 4'hf, 1'b0, '0);
        bus_access(reg_adr(`REGION_IRQ, `IC_STATUS), 4'hf, 1'b0, '0);
        bus_access(reg_adr(`REGION_TIMER, `TMR_CLEAR), 4'hf, 1'b1, 32'h1);
        // External line through both masks
        bus_access(reg_adr(`REGION_IRQ, `IC_FIRQ_EN), 4'hf, 1'b1, 32'h2);
        bus_access(reg_adr(`REGION_IRQ, `IC_IRQ_EN), 4'hf, 1'b1, 32'h2);
        ext_irq = 1'b1;
        @(negedge brd_clk);
        bus_access(reg_adr(`REGION_IRQ, `IC_STATUS), 4'hf, 1'b0, '0);
        bus_access(reg_adr(`REGION_IRQ, `IC_FIRQ_EN), 4'hf, 1'b1, 32'h0);
        ext_irq = 1'b0;
        bus_access(reg_adr(`REGION_IRQ, `IC_STATUS), 4'hf, 1'b0, '0);
        repeat (4) @(negedge brd_clk);
        if (i_dut.u_chk.fail_cnt == 0) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            $display("TEST RESULT: FAIL");
            $fatal(1, "%0d assertion failures in the checker", i_dut.u_chk.fail_cnt);
        end
    end

    // Stop at the first assertion failure
    initial begin
        wait (i_dut.u_chk.fail_cnt != 0);
        $display("TEST RESULT: FAIL");
        $fatal(1, "Assertion failure reported by the bound checker");
    end

    // Watchdog
    initial begin
        repeat (WD_CYC) @(posedge brd_clk);
        $display("TEST RESULT: FAIL");
        $fatal(1, "Watchdog timeout after %0d cycles, a bus access or interrupt never came",
               WD_CYC);
    end

endmodule

// File: files.f
+incdir+include
hw/sys_pkg.sv
hw/rst_stretch.sv
hw/wb_decoder.sv
hw/boot_ram.sv
hw/timer_block.sv
hw/irq_ctrl.sv
hw/soc_top.sv
testbench/soc_checker.sv
testbench/tb_top.sv

// File: Bender.yml
package:
  name: soc_system

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/sys_pkg.sv
      - hw/rst_stretch.sv
      - hw/wb_decoder.sv
      - hw/boot_ram.sv
      - hw/timer_block.sv
      - hw/irq_ctrl.sv
      - hw/soc_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/soc_checker.sv
      - testbench/tb_top.sv
